// ==== src/wb_ram_pkg.sv ====
package wb_ram_pkg;

   // Bus geometry
   localparam int wb_aw = 32;        // Byte address width
   localparam int wb_dw = 32;        // Data width
   localparam int wb_sw = wb_dw / 8; // One select per byte lane

   // Cycle type identifier, Wishbone B3 encoding
   typedef enum logic [2:0] {
      CTI_CLASSIC = 3'd0, // Single transfer, one wait state
      CTI_CONST   = 3'd1, // Burst on a fixed address
      CTI_INCR    = 3'd2, // Burst with incrementing address
      CTI_END     = 3'd7  // Last beat of a burst
   } cti_e;

   // Burst type extension, only meaningful with CTI_INCR
   typedef enum logic [1:0] {
      BTE_LINEAR = 2'd0,
      BTE_WRAP4  = 2'd1, // Wrap on 4-word boundary
      BTE_WRAP8  = 2'd2,
      BTE_WRAP16 = 2'd3
   } bte_e;

   // Master to slave
   typedef struct packed {
      logic [wb_aw-1:0] adr; // Byte address
      logic [wb_dw-1:0] dat; // Write data
      logic [wb_sw-1:0] sel; // Byte lane enables
      logic             we;
      bte_e             bte;
      cti_e             cti;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      logic [wb_dw-1:0] dat; // Read data
      logic             ack; // Normal termination
      logic             err; // Error termination
   } wb_rsp_t;

endpackage

// ==== src/wb_burst_tracker.sv ====
`timescale 1ns/1ps

module wb_burst_tracker #(
   parameter int mem_adr_width = 12 // Byte address bits decoded into the RAM
) (
   input  logic                     wb_clk_i,
   input  logic                     wb_rst_i,
   input  wb_ram_pkg::wb_req_t      req_i,
   input  logic                     ack_i,
   input  logic                     err_i,
   output logic [mem_adr_width-3:0] word_adr_o,
   output logic                     adr_mismatch_o
);
   import wb_ram_pkg::*;

   localparam int word_w = mem_adr_width - 2; // Word address bits

   logic              burst_q;      // Registered-feedback burst in progress
   cti_e              cti_q;        // Cycle type of the previous edge
   bte_e              bte_q;        // Burst type of the previous edge
   logic [word_w-1:0] bus_word_adr; // Word address taken from the bus
   logic [word_w-1:0] wrap_mask;    // Bits allowed to count
   logic [word_w-1:0] adr_inc;      // Plain increment of the held address
   logic [word_w-1:0] burst_adr;    // Next address inside a burst
   logic              is_burst_cti;
   logic              burst_start;
   logic              burst_stop;

   assign bus_word_adr = req_i.adr[mem_adr_width-1:2]; // Drop byte offset

   // Burst detection
   assign is_burst_cti = (req_i.cti == CTI_CONST) || (req_i.cti == CTI_INCR);
   assign burst_start  = is_burst_cti & req_i.cyc & req_i.stb & ~burst_q;

   // Leaves on the acked end beat, or on any error termination
   assign burst_stop = ((req_i.cti == CTI_END) & req_i.stb & burst_q & ack_i) | err_i;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         burst_q <= 1'b0;
      end else if (burst_start) begin
         burst_q <= 1'b1;
      end else if (burst_stop) begin
         burst_q <= 1'b0;
      end
   end

   // Cycle and burst type as seen one edge ago
   // They describe the beat whose address is held in word_adr_o
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         cti_q <= CTI_CLASSIC;
         bte_q <= BTE_LINEAR;
      end else begin
         cti_q <= req_i.cti;
         bte_q <= req_i.bte;
      end
   end

   // Which low bits may count for each burst type
   always_comb begin
      case (bte_q)
         BTE_WRAP4:  wrap_mask = word_w'(3);  // Low 2 bits
         BTE_WRAP8:  wrap_mask = word_w'(7);  // Low 3 bits
         BTE_WRAP16: wrap_mask = word_w'(15); // Low 4 bits
         default:    wrap_mask = '1;          // Linear, carry runs through
      endcase
   end

   assign adr_inc = word_adr_o + 1'b1;

   // Next burst address
   always_comb begin
      burst_adr = word_adr_o; // Hold in wait states and constant bursts
      if ((cti_q == CTI_INCR) && ack_i) begin
         // Upper bits stay, masked bits take the increment
         burst_adr = (word_adr_o & ~wrap_mask) | (adr_inc & wrap_mask);
      end
   end

   // Registered word address, the only address the RAM sees
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         word_adr_o <= '0;
      end else if (burst_q) begin
         word_adr_o <= burst_adr;
      end else if (req_i.cyc && req_i.stb) begin
         word_adr_o <= bus_word_adr; // Classic or first burst beat
      end
   end

   // Master left the expected sequence
   assign adr_mismatch_o = burst_q & (bus_word_adr != word_adr_o);

endmodule

// ==== src/wb_ack_ctrl.sv ====
`timescale 1ns/1ps

module wb_ack_ctrl (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  wb_ram_pkg::wb_req_t req_i,
   input  logic                adr_mismatch_i,
   output logic                ack_o,
   output logic                err_o
);
   import wb_ram_pkg::*;

   logic ack_q; // Registered acknowledge, before stb qualification
   logic stb_live;

   // Response only counts while the master strobes
   assign stb_live = req_i.cyc & req_i.stb;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
      end else if (req_i.cyc) begin
         case (req_i.cti)
            CTI_CONST,
            CTI_INCR: begin
               ack_q <= req_i.stb; // Zero wait states once started
            end
            CTI_END: begin
               // Follows an acked beat, so drop after this one
               ack_q <= req_i.stb & ~ack_q;
            end
            default: begin
               // Classic and reserved types
               // Toggle gives one wait state per transfer
               ack_q <= req_i.stb ^ ack_q;
            end
         endcase
      end else begin
         ack_q <= 1'b0; // Bus released
      end
   end

   // A wrong burst address turns the ack into an err
   assign ack_o = ack_q & stb_live & ~adr_mismatch_i;
   assign err_o = ack_q & stb_live & adr_mismatch_i;

endmodule

// ==== src/wb_ram_array.sv ====
`timescale 1ns/1ps

module wb_ram_array #(
   parameter int mem_adr_width = 12 // Byte address bits decoded into the RAM
) (
   input  logic                        wb_clk_i,
   input  logic [mem_adr_width-3:0]    word_adr_i,
   input  wb_ram_pkg::wb_req_t         req_i,
   input  logic                        ack_i,
   output logic [wb_ram_pkg::wb_dw-1:0] dat_o
);
   import wb_ram_pkg::*;

   localparam int mem_words = 2 ** (mem_adr_width - 2);

   logic [wb_dw-1:0] mem [mem_words]; // Word storage, no reset
   logic             wr_en;

   // Write only on a normally terminated beat
   // An err beat never reaches the array
   assign wr_en = req_i.we & ack_i;

   // Byte lane writes
   always_ff @(posedge wb_clk_i) begin
      if (wr_en) begin
         for (int lane = 0; lane < wb_sw; lane++) begin
            if (req_i.sel[lane]) begin
               mem[word_adr_i][8*lane +: 8] <= req_i.dat[8*lane +: 8];
            end
         end
      end
   end

   // Asynchronous read of the registered address
   // Valid by the time ack rises
   assign dat_o = mem[word_adr_i];

endmodule

// ==== src/wb_ram_top.sv ====
`timescale 1ns/1ps

module wb_ram_top #(
   parameter int mem_adr_width = 12 // 1024 words by default
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  wb_ram_pkg::wb_req_t wb_req_i,
   output wb_ram_pkg::wb_rsp_t wb_rsp_o
);
   import wb_ram_pkg::*;

   logic [mem_adr_width-3:0] word_adr;     // Tracker to array
   logic                     adr_mismatch; // Tracker to ack control
   logic                     ack;
   logic                     err;
   logic [wb_dw-1:0]         rd_dat;

   // Input side, burst address tracking
   wb_burst_tracker #(
      .mem_adr_width (mem_adr_width)
   ) wb_burst_tracker_i (
      .wb_clk_i       (wb_clk_i),
      .wb_rst_i       (wb_rst_i),
      .req_i          (wb_req_i),
      .ack_i          (ack),
      .err_i          (err),
      .word_adr_o     (word_adr),
      .adr_mismatch_o (adr_mismatch)
   );

   // Cycle termination
   wb_ack_ctrl wb_ack_ctrl_i (
      .wb_clk_i       (wb_clk_i),
      .wb_rst_i       (wb_rst_i),
      .req_i          (wb_req_i),
      .adr_mismatch_i (adr_mismatch),
      .ack_o          (ack),
      .err_o          (err)
   );

   // Output side, storage
   wb_ram_array #(
      .mem_adr_width (mem_adr_width)
   ) wb_ram_array_i (
      .wb_clk_i   (wb_clk_i),
      .word_adr_i (word_adr),
      .req_i      (wb_req_i),
      .ack_i      (ack),
      .dat_o      (rd_dat)
   );

   // Slave response bundle
   assign wb_rsp_o = '{dat: rd_dat, ack: ack, err: err};

endmodule

// ==== testbench/wb_ram_tb.sv ====
`timescale 1ns/1ps

module wb_ram_tb;
   import wb_ram_pkg::*;

   localparam int mem_adr_width = 12;                // 1024 words in the DUT
   localparam int word_w        = mem_adr_width - 2; // Word address bits
   localparam int mem_words     = 2 ** word_w;
   localparam int clk_half      = 20;                // 40 ns period
   localparam int sample_dly    = 5;                 // Sample point after the falling edge
   localparam int rsp_timeout   = 8;                 // Cycles allowed per beat
   localparam int n_rows        = 23;

   localparam logic [31:0] lfsr_taps = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] lfsr_seed = 32'd25;

   // Transaction kinds of the table
   typedef enum logic [1:0] {
      CL_RD, // Classic read
      CL_WR, // Classic write
      BU_RD, // Burst read
      BU_WR  // Burst write
   } kind_e;

   typedef struct packed {
      kind_e            kind;
      cti_e             cti;      // Type of every beat but the last
      bte_e             bte;
      logic [wb_aw-1:0] adr;      // Start byte address
      int               beats;
      logic [wb_sw-1:0] sel;
      int               bad_beat; // Beat carrying a wrong address (0 for none)
   } xfer_t;

   logic             wb_clk_i;
   logic             wb_rst_i;
   wb_req_t          wb_req;
   wb_rsp_t          wb_rsp;

   xfer_t            xfer_tbl [n_rows];
   logic [wb_dw-1:0] shadow [mem_words]; // Predicted memory contents
   logic [31:0]      lfsr_q;
   string            where;              // Row and beat named in error lines

   wb_ram_top #(
      .mem_adr_width (mem_adr_width)
   ) wb_ram_top_i (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp)
   );

   always #(clk_half) wb_clk_i = ~wb_clk_i;

   // Galois form shifting right and folding the taps in on a one
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ lfsr_taps;
      end
      return s >> 1;
   endfunction

   // One LFSR step per data bit
   task automatic draw_word(output logic [wb_dw-1:0] w);
      w = '0;
      for (int i = 0; i < wb_dw; i++) begin
         w      = {w[wb_dw-2:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   // Word that follows w inside a burst
   function automatic logic [word_w-1:0] next_word(input logic [word_w-1:0] w,
                                                   input cti_e cti, input bte_e bte);
      int span;
      int base;
      if (cti != CTI_INCR) begin
         return w; // Constant address
      end
      case (bte)
         BTE_WRAP4:  span = 4;
         BTE_WRAP8:  span = 8;
         BTE_WRAP16: span = 16;
         default:    span = mem_words; // Linear rolls over at the top
      endcase
      base = int'(w) - (int'(w) % span);               // Aligned block start
      return word_w'(base + ((int'(w) - base + 1) % span));
   endfunction

   function automatic logic [wb_aw-1:0] word_to_adr(input logic [word_w-1:0] w);
      return {{(wb_aw - mem_adr_width){1'b0}}, w, 2'b00};
   endfunction

   // Byte lane rule of the RAM
   task automatic shadow_write(input logic [word_w-1:0] w, input logic [wb_dw-1:0] dat,
                               input logic [wb_sw-1:0] sel);
      for (int lane = 0; lane < wb_sw; lane++) begin
         if (sel[lane]) begin
            shadow[w][8*lane +: 8] = dat[8*lane +: 8];
         end
      end
   endtask

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_dat(input string name, input logic [wb_dw-1:0] exp,
                            input logic [wb_dw-1:0] act);
      if (act !== exp) begin
         stop_on_error($sformatf("FAILED %s expected 0x%08h actual 0x%08h at %s",
                                 name, exp, act, where));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_on_error($sformatf("FAILED %s expected 0x%0h actual 0x%0h at %s",
                                 name, exp, act, where));
      end
   endtask

   // Present one beat on the falling edge
   task automatic drive_beat(input logic [wb_aw-1:0] adr, input logic [wb_dw-1:0] dat,
                             input logic [wb_sw-1:0] sel, input logic we,
                             input cti_e cti, input bte_e bte);
      @(negedge wb_clk_i);
      wb_req.adr = adr;
      wb_req.dat = dat;
      wb_req.sel = sel;
      wb_req.we  = we;
      wb_req.cti = cti;
      wb_req.bte = bte;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
   endtask

   // Drop cyc and stb and expect a quiet slave
   task automatic release_bus();
      @(negedge wb_clk_i);
      wb_req = '0;
      #(sample_dly);
      check_flag("wb_rsp_o.ack", 1'b0, wb_rsp.ack);
      check_flag("wb_rsp_o.err", 1'b0, wb_rsp.err);
   endtask

   // Count cycles until ack or err as sampled mid low phase
   task automatic wait_rsp(output int cycles);
      cycles = 0;
      #(sample_dly);
      while (!(wb_rsp.ack || wb_rsp.err)) begin
         if (cycles >= rsp_timeout) begin
            stop_on_error($sformatf("Timeout, no ack or err within %0d cycles at %s",
                                    rsp_timeout, where));
         end else begin
            @(negedge wb_clk_i);
            #(sample_dly);
            cycles++;
         end
      end
   endtask

   task automatic run_row(input xfer_t r, input int idx);
      logic [word_w-1:0] w;
      logic [word_w-1:0] start_w;
      logic [wb_aw-1:0]  adr;
      logic [wb_dw-1:0]  dat;
      logic              is_wr;
      logic              is_classic;
      logic              bad;
      cti_e              cti;
      int                cycles;
      int                exp_lat;
      start_w    = r.adr[mem_adr_width-1:2];
      w          = start_w;
      is_wr      = (r.kind == CL_WR) || (r.kind == BU_WR);
      is_classic = (r.kind == CL_RD) || (r.kind == CL_WR);
      for (int b = 0; b < r.beats; b++) begin
         where = $sformatf("row %0d beat %0d", idx, b);
         if (is_classic) begin
            cti = CTI_CLASSIC;
         end else if (b == r.beats - 1) begin
            cti = CTI_END; // Last beat closes the burst
         end else begin
            cti = r.cti;
         end
         bad = (r.bad_beat != 0) && (b == r.bad_beat);
         adr = bad ? word_to_adr(start_w) : word_to_adr(w); // Jump back to the start
         dat = '0;
         if (is_wr) begin
            draw_word(dat);
         end
         drive_beat(adr, dat, r.sel, is_wr, cti, r.bte);
         wait_rsp(cycles);
         exp_lat = (b == 0) ? 1 : 0; // One wait state then back to back
         if (cycles != exp_lat) begin
            stop_on_error($sformatf("Response came %0d cycles after stb, expected %0d at %s",
                                    cycles, exp_lat, where));
         end
         if (bad) begin
            check_flag("wb_rsp_o.err", 1'b1, wb_rsp.err);
            check_flag("wb_rsp_o.ack", 1'b0, wb_rsp.ack);
            break; // Master abandons the burst
         end
         check_flag("wb_rsp_o.ack", 1'b1, wb_rsp.ack);
         check_flag("wb_rsp_o.err", 1'b0, wb_rsp.err);
         if (is_wr) begin
            shadow_write(w, dat, r.sel);
         end else begin
            check_dat("wb_rsp_o.dat", shadow[w], wb_rsp.dat);
         end
         w = next_word(w, cti, r.bte);
      end
      release_bus();
   endtask

   // kind, cti, bte, start, beats, sel, bad beat
   task automatic load_table();
      xfer_tbl[0]  = '{CL_WR, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0040, 1, 4'hF, 0};
      xfer_tbl[1]  = '{CL_RD, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0040, 1, 4'hF, 0};
      xfer_tbl[2]  = '{CL_WR, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0080, 1, 4'hF, 0};
      xfer_tbl[3]  = '{CL_WR, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0080, 1, 4'h1, 0};
      xfer_tbl[4]  = '{CL_WR, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0080, 1, 4'h6, 0};
      xfer_tbl[5]  = '{CL_WR, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0080, 1, 4'h8, 0};
      xfer_tbl[6]  = '{CL_RD, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0080, 1, 4'hF, 0};
      xfer_tbl[7]  = '{BU_WR, CTI_INCR,    BTE_LINEAR, 32'h0000_0100, 8, 4'hF, 0};
      xfer_tbl[8]  = '{BU_RD, CTI_INCR,    BTE_LINEAR, 32'h0000_0100, 8, 4'hF, 0};
      xfer_tbl[9]  = '{BU_WR, CTI_CONST,   BTE_LINEAR, 32'h0000_0200, 4, 4'hF, 0};
      xfer_tbl[10] = '{BU_RD, CTI_CONST,   BTE_LINEAR, 32'h0000_0200, 4, 4'hF, 0};
      xfer_tbl[11] = '{BU_WR, CTI_INCR,    BTE_WRAP4,  32'h0000_0308, 4, 4'hF, 0};
      xfer_tbl[12] = '{BU_RD, CTI_INCR,    BTE_WRAP4,  32'h0000_0308, 4, 4'hF, 0};
      xfer_tbl[13] = '{BU_WR, CTI_INCR,    BTE_WRAP8,  32'h0000_0414, 8, 4'hF, 0};
      xfer_tbl[14] = '{BU_RD, CTI_INCR,    BTE_WRAP8,  32'h0000_0414, 8, 4'hF, 0};
      xfer_tbl[15] = '{BU_WR, CTI_INCR,    BTE_WRAP16, 32'h0000_05A4, 16, 4'hF, 0};
      xfer_tbl[16] = '{BU_RD, CTI_INCR,    BTE_WRAP16, 32'h0000_05A4, 16, 4'hF, 0};
      xfer_tbl[17] = '{BU_WR, CTI_INCR,    BTE_LINEAR, 32'h0000_0600, 4, 4'hF, 0};
      xfer_tbl[18] = '{BU_WR, CTI_INCR,    BTE_LINEAR, 32'h0000_0600, 4, 4'hF, 2};
      xfer_tbl[19] = '{CL_RD, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0600, 1, 4'hF, 0};
      xfer_tbl[20] = '{CL_RD, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0608, 1, 4'hF, 0};
      xfer_tbl[21] = '{BU_RD, CTI_INCR,    BTE_LINEAR, 32'h0000_0100, 4, 4'hF, 1};
      xfer_tbl[22] = '{CL_RD, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0604, 1, 4'hF, 0};
   endtask

   initial begin
      wb_clk_i   = 1'b0;
      wb_rst_i   = 1'b1;
      wb_req     = '0;
      wb_req.cyc = 1'b1; // Classic read held through reset
      wb_req.stb = 1'b1; // Only reset keeps it unanswered
      lfsr_q     = lfsr_seed;
      where      = "reset";
      load_table();

      // Reset over three rising edges and released on the third falling edge
      for (int c = 0; c < 3; c++) begin
         @(negedge wb_clk_i);
         if (c == 2) begin
            wb_rst_i = 1'b0;
            wb_req   = '0;
         end
         #(sample_dly);
         check_flag("wb_rsp_o.ack", 1'b0, wb_rsp.ack);
         check_flag("wb_rsp_o.err", 1'b0, wb_rsp.err);
      end
      release_bus(); // One idle cycle after reset

      for (int i = 0; i < n_rows; i++) begin
         run_row(xfer_tbl[i], i);
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== wb_ram_top.f ====
src/wb_ram_pkg.sv
src/wb_burst_tracker.sv
src/wb_ack_ctrl.sv
src/wb_ram_array.sv
src/wb_ram_top.sv
testbench/wb_ram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Wishbone RAM testbench with Verilator and run it
# Exit status is zero only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module wb_ram_tb \
   -f wb_ram_top.f \
   -o wb_ram_sim \
   && ./obj_dir/wb_ram_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
   && echo "run_sim: pass" \
   || { echo "run_sim: fail"; exit 1; }
